// ==== rtl/isaPkg.sv ====
package isaPkg;

   localparam int regIdxW = 3;

   // Opcodes in bits 15:11
   localparam logic [4:0] opHalt = 5'b00000;
   localparam logic [4:0] opJ    = 5'b00100;
   localparam logic [4:0] opAddi = 5'b01000;
   localparam logic [4:0] opBeqz = 5'b01100;
   localparam logic [4:0] opSt   = 5'b10000;
   localparam logic [4:0] opLd   = 5'b10001;
   localparam logic [4:0] opAdd  = 5'b11000;
   localparam logic [4:0] opSub  = 5'b11001;
   localparam logic [4:0] opAnd  = 5'b11010;
   localparam logic [4:0] opXor  = 5'b11011;

   // One instruction word, read through whichever format the opcode calls for
   typedef union packed {
      struct packed {
         logic [4:0]         opcode;
         logic [regIdxW-1:0] rs;
         logic [regIdxW-1:0] rt;
         logic [regIdxW-1:0] rd;
         logic [1:0]         unused;
      } rFmt;
      struct packed {
         logic [4:0]         opcode;
         logic [regIdxW-1:0] rs;
         logic [regIdxW-1:0] rd;
         logic [4:0]         imm5;
      } iFmt;
      struct packed {
         logic [4:0]         opcode;
         logic [regIdxW-1:0] rs;
         logic [7:0]         imm8;
      } bFmt;
      struct packed {
         logic [4:0]  opcode;
         logic [10:0] disp11;
      } jFmt;
   } instrT;

   // Bubble word, ADDI r0,r0,0; decode never lets it write
   localparam logic [15:0] nopWord = {opAddi, 11'd0};

endpackage

// ==== rtl/pipePkg.sv ====
package pipePkg;

   // ALU operations
   localparam int aluOpW = 2;
   localparam logic [aluOpW-1:0] aluAdd = 2'd0;
   localparam logic [aluOpW-1:0] aluSub = 2'd1;
   localparam logic [aluOpW-1:0] aluAnd = 2'd2;
   localparam logic [aluOpW-1:0] aluXor = 2'd3;

   // Writeback source
   localparam int wbSrcW = 1;
   localparam logic [wbSrcW-1:0] wbAlu = 1'b0;
   localparam logic [wbSrcW-1:0] wbMem = 1'b1;

   // Operand forward selects
   localparam int fwdW = 2;
   localparam logic [fwdW-1:0] fwdReg   = 2'd0;
   localparam logic [fwdW-1:0] fwdExMem = 2'd1;
   localparam logic [fwdW-1:0] fwdMemWb = 2'd2;

endpackage

// ==== rtl/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage #(
   parameter int imemDepth = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         loadEn,
   input  logic [$clog2(imemDepth)-1:0] loadAddr,
   input  logic [15:0]                  loadData,
   input  logic                         stall,
   input  logic                         redirect,
   input  logic [15:0]                  redirectPc,
   input  logic                         stopFetch,
   output isaPkg::instrT                ifInstr,
   output logic [15:0]                  ifPcNext
);
   import isaPkg::*;

   localparam int addrW = $clog2(imemDepth);

   logic [15:0] imem [imemDepth];
   logic [15:0] pc;
   logic [15:0] pcNext;

   assign pcNext = pc + 16'd1;

   // Program load, only while the core is held in reset
   always_ff @(posedge clk) begin
      if (rst && loadEn) begin
         imem[loadAddr] <= loadData;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         pc <= 16'd0;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall && !stopFetch) begin
         pc <= pcNext;
      end
   end

   // Fetch/decode register; squashed slots become bubbles
   always_ff @(posedge clk) begin
      if (rst || redirect) begin
         ifInstr <= nopWord;
      end else if (!stall) begin
         ifInstr <= stopFetch ? nopWord : imem[pc[addrW-1:0]];
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ifPcNext <= pcNext;
      end
   end

   aLoadInReset: assert property (@(posedge clk) loadEn |-> rst)
      else $error("instruction memory load outside reset");

endmodule

// ==== rtl/decodeStage.sv ====
`timescale 1ns/10ps

module decodeStage (
   input  logic                       clk,
   input  logic                       rst,
   input  isaPkg::instrT              ifInstr,
   input  logic [15:0]                ifPcNext,
   input  logic                       stall,
   input  logic                       redirect,
   input  logic                       wbValid,
   input  logic [isaPkg::regIdxW-1:0] wbRd,
   input  logic [15:0]                wbData,
   output logic [15:0]                exRsData,
   output logic [15:0]                exRtData,
   output logic [15:0]                exImm,
   output logic [15:0]                exPcNext,
   output logic [isaPkg::regIdxW-1:0] exRs,
   output logic [isaPkg::regIdxW-1:0] exRt,
   output logic [isaPkg::regIdxW-1:0] exRd,
   output logic [pipePkg::aluOpW-1:0] exAluOp,
   output logic                       exUseImm,
   output logic                       exRegWrt,
   output logic                       exMemRead,
   output logic                       exMemWrt,
   output logic                       exBranch,
   output logic                       exJump,
   output logic                       exHalt,
   output logic                       exIllegal,
   output logic [isaPkg::regIdxW-1:0] idRs,
   output logic [isaPkg::regIdxW-1:0] idRt
);
   import isaPkg::*;
   import pipePkg::*;

   logic [15:0] regFile [1 << regIdxW];
   logic [15:0] rsData;
   logic [15:0] rtData;
   logic [15:0] imm;
   logic [regIdxW-1:0] rd;
   logic [aluOpW-1:0] aluOp;
   logic useImm, regWrt, memRead, memWrt;
   logic branch, jump, halt, illegal;

   // Bits 7:5 are rt for R-type and the store data register for ST
   assign idRs = ifInstr.rFmt.rs;
   assign idRt = ifInstr.rFmt.rt;

   always_ff @(posedge clk) begin
      if (wbValid) begin
         regFile[wbRd] <= wbData;
      end
   end

   // Write-through so a same-cycle writeback is seen
   assign rsData = (wbValid && wbRd == idRs) ? wbData : regFile[idRs];
   assign rtData = (wbValid && wbRd == idRt) ? wbData : regFile[idRt];

   always_comb begin
      aluOp   = aluAdd;
      useImm  = 1'b0;
      regWrt  = 1'b0;
      memRead = 1'b0;
      memWrt  = 1'b0;
      branch  = 1'b0;
      jump    = 1'b0;
      halt    = 1'b0;
      illegal = 1'b0;
      rd      = ifInstr.iFmt.rd;
      imm     = {{11{ifInstr.iFmt.imm5[4]}}, ifInstr.iFmt.imm5};
      case (ifInstr.rFmt.opcode)
         opAdd, opSub, opAnd, opXor: begin
            regWrt = 1'b1;
            rd     = ifInstr.rFmt.rd;
            case (ifInstr.rFmt.opcode)
               opSub:   aluOp = aluSub;
               opAnd:   aluOp = aluAnd;
               opXor:   aluOp = aluXor;
               default: aluOp = aluAdd;
            endcase
         end
         opAddi: begin
            useImm = 1'b1;
            regWrt = (ifInstr != nopWord);
         end
         opLd: begin
            useImm  = 1'b1;
            regWrt  = 1'b1;
            memRead = 1'b1;
         end
         opSt: begin
            useImm = 1'b1;
            memWrt = 1'b1;
         end
         opBeqz: begin
            branch = 1'b1;
            imm    = {{8{ifInstr.bFmt.imm8[7]}}, ifInstr.bFmt.imm8};
         end
         opJ: begin
            jump = 1'b1;
            imm  = {{5{ifInstr.jFmt.disp11[10]}}, ifInstr.jFmt.disp11};
         end
         opHalt:  halt = 1'b1;
         default: illegal = 1'b1;
      endcase
   end

   // Decode/execute control, bubble on stall or squash
   always_ff @(posedge clk) begin
      if (rst || stall || redirect) begin
         exRegWrt  <= 1'b0;
         exMemRead <= 1'b0;
         exMemWrt  <= 1'b0;
         exBranch  <= 1'b0;
         exJump    <= 1'b0;
         exHalt    <= 1'b0;
         exIllegal <= 1'b0;
      end else begin
         exRegWrt  <= regWrt;
         exMemRead <= memRead;
         exMemWrt  <= memWrt;
         exBranch  <= branch;
         exJump    <= jump;
         exHalt    <= halt;
         exIllegal <= illegal;
      end
   end

   always_ff @(posedge clk) begin
      exRsData <= rsData;
      exRtData <= rtData;
      exImm    <= imm;
      exPcNext <= ifPcNext;
      exRs     <= idRs;
      exRt     <= idRt;
      exRd     <= rd;
      exAluOp  <= aluOp;
      exUseImm <= useImm;
   end

   aLdStExclusive: assert property (@(posedge clk) disable iff (rst)
      !(exMemRead && exMemWrt))
      else $error("load and store set together in execute");

endmodule

// ==== rtl/hazardUnit.sv ====
`timescale 1ns/10ps

module hazardUnit (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [isaPkg::regIdxW-1:0] idRs,
   input  logic [isaPkg::regIdxW-1:0] idRt,
   input  logic [isaPkg::regIdxW-1:0] exRd,
   input  logic                       exRegWrt,
   input  logic                       exMemRead,
   input  logic [isaPkg::regIdxW-1:0] memRd,
   input  logic                       memRegWrt,
   output logic                       stall,
   output logic [pipePkg::fwdW-1:0]   fwdA,
   output logic [pipePkg::fwdW-1:0]   fwdB
);
   import pipePkg::*;

   // Producers one stage on by the time the operand reaches execute
   function automatic logic [fwdW-1:0] pickSrc(input logic [2:0] src);
      if (exRegWrt && exRd == src) begin
         return fwdExMem;
      end else if (memRegWrt && memRd == src) begin
         return fwdMemWb;
      end
      return fwdReg;
   endfunction

   // Load result is not ready for the next instruction
   assign stall = exMemRead && (exRd == idRs || exRd == idRt);

   always_ff @(posedge clk) begin
      if (rst || stall) begin
         fwdA <= fwdReg;
         fwdB <= fwdReg;
      end else begin
         fwdA <= pickSrc(idRs);
         fwdB <= pickSrc(idRt);
      end
   end

   aSingleStall: assert property (@(posedge clk) disable iff (rst) stall |=> !stall)
      else $error("load-use stall held for two cycles");

endmodule

// ==== rtl/executeStage.sv ====
`timescale 1ns/10ps

module executeStage (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [15:0]                exRsData,
   input  logic [15:0]                exRtData,
   input  logic [15:0]                exImm,
   input  logic [15:0]                exPcNext,
   input  logic [isaPkg::regIdxW-1:0] exRs,
   input  logic [isaPkg::regIdxW-1:0] exRt,
   input  logic [isaPkg::regIdxW-1:0] exRd,
   input  logic [pipePkg::aluOpW-1:0] exAluOp,
   input  logic                       exUseImm,
   input  logic                       exRegWrt,
   input  logic                       exMemRead,
   input  logic                       exMemWrt,
   input  logic                       exBranch,
   input  logic                       exJump,
   input  logic                       exHalt,
   input  logic                       exIllegal,
   input  logic [pipePkg::fwdW-1:0]   fwdA,
   input  logic [pipePkg::fwdW-1:0]   fwdB,
   input  logic [15:0]                wbData,
   output logic                       redirect,
   output logic [15:0]                redirectPc,
   output logic [15:0]                memAlu,
   output logic [15:0]                memStoreData,
   output logic [isaPkg::regIdxW-1:0] memRd,
   output logic                       memRegWrt,
   output logic                       memMemRead,
   output logic                       memMemWrt,
   output logic                       memHalt,
   output logic                       memIllegal
);
   import pipePkg::*;

   logic [15:0] opA;
   logic [15:0] opB;
   logic [15:0] aluIn;
   logic [15:0] aluOut;
   logic squash;

   function automatic logic [15:0] fwdMux(input logic [fwdW-1:0] sel,
                                          input logic [15:0] regVal,
                                          input logic [15:0] exMemVal,
                                          input logic [15:0] memWbVal);
      case (sel)
         fwdExMem: return exMemVal;
         fwdMemWb: return memWbVal;
         default:  return regVal;
      endcase
   endfunction

   assign opA   = fwdMux(fwdA, exRsData, memAlu, wbData);
   assign opB   = fwdMux(fwdB, exRtData, memAlu, wbData);
   assign aluIn = exUseImm ? exImm : opB;

   always_comb begin
      case (exAluOp)
         aluSub:  aluOut = opA - aluIn;
         aluAnd:  aluOut = opA & aluIn;
         aluXor:  aluOut = opA ^ aluIn;
         default: aluOut = opA + aluIn;
      endcase
   end

   // HALT or illegal one stage ahead also clears everything younger
   assign squash     = memHalt || memIllegal;
   assign redirect   = exJump || (exBranch && opA == 16'd0) || squash;
   assign redirectPc = exPcNext + exImm;

   always_ff @(posedge clk) begin
      if (rst || squash) begin
         memRegWrt  <= 1'b0;
         memMemRead <= 1'b0;
         memMemWrt  <= 1'b0;
         memHalt    <= 1'b0;
         memIllegal <= 1'b0;
      end else begin
         memRegWrt  <= exRegWrt;
         memMemRead <= exMemRead;
         memMemWrt  <= exMemWrt;
         memHalt    <= exHalt;
         memIllegal <= exIllegal;
      end
   end

   always_ff @(posedge clk) begin
      memAlu       <= aluOut;
      memStoreData <= opB;
      memRd        <= exRd;
   end

   // Forward picks from the hazard unit must match the producer in memory
   aFwdA: assert property (@(posedge clk) disable iff (rst)
      (exRegWrt || exMemWrt) && fwdA == fwdExMem |-> memRegWrt && memRd == exRs)
      else $error("operand A forwarded from wrong producer");
   aFwdB: assert property (@(posedge clk) disable iff (rst)
      (exRegWrt || exMemWrt) && fwdB == fwdExMem |-> memRegWrt && memRd == exRt)
      else $error("operand B forwarded from wrong producer");

endmodule

// ==== rtl/memoryStage.sv ====
`timescale 1ns/10ps

module memoryStage #(
   parameter int dmemDepth = 256
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic [15:0]                memAlu,
   input  logic [15:0]                memStoreData,
   input  logic [isaPkg::regIdxW-1:0] memRd,
   input  logic                       memRegWrt,
   input  logic                       memMemRead,
   input  logic                       memMemWrt,
   input  logic                       memHalt,
   input  logic                       memIllegal,
   output logic                       wbValid,
   output logic [isaPkg::regIdxW-1:0] wbRd,
   output logic [15:0]                wbData,
   output logic                       halted,
   output logic                       err,
   output logic                       stopFetch
);
   import pipePkg::*;

   localparam int addrW = $clog2(dmemDepth);

   logic [15:0] dmem [dmemDepth];
   logic [15:0] readData;
   logic [wbSrcW-1:0] wbSrc;

   always_ff @(posedge clk) begin
      if (memMemWrt) begin
         dmem[memAlu[addrW-1:0]] <= memStoreData;
      end
   end

   assign readData = dmem[memAlu[addrW-1:0]];
   assign wbSrc    = memMemRead ? wbMem : wbAlu;

   always_ff @(posedge clk) begin
      wbRd   <= memRd;
      wbData <= (wbSrc == wbMem) ? readData : memAlu;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wbValid <= 1'b0;
         halted  <= 1'b0;
         err     <= 1'b0;
      end else begin
         wbValid <= memRegWrt;
         // Sticky until reset
         if (memHalt || memIllegal) begin
            halted <= 1'b1;
         end
         if (memIllegal) begin
            err <= 1'b1;
         end
      end
   end

   assign stopFetch = halted || memHalt;

endmodule

// ==== rtl/proc.sv ====
`timescale 1ns/10ps

module proc #(
   parameter int imemDepth = 256,
   parameter int dmemDepth = 256
) (
   input  logic                         clk,
   input  logic                         rst,
   input  logic                         loadEn,
   input  logic [$clog2(imemDepth)-1:0] loadAddr,
   input  logic [15:0]                  loadData,
   output logic                         retire,
   output logic [isaPkg::regIdxW-1:0]   retireReg,
   output logic [15:0]                  retireData,
   output logic                         halted,
   output logic                         err
);
   import isaPkg::*;
   import pipePkg::*;

   // Fetch to decode
   instrT ifInstr;
   logic [15:0] ifPcNext;

   // Decode to execute
   logic [15:0] exRsData, exRtData, exImm, exPcNext;
   logic [regIdxW-1:0] exRs, exRt, exRd, idRs, idRt;
   logic [aluOpW-1:0] exAluOp;
   logic exUseImm, exRegWrt, exMemRead, exMemWrt;
   logic exBranch, exJump, exHalt, exIllegal;

   // Hazard and control feedback
   logic stall, redirect, stopFetch;
   logic [15:0] redirectPc;
   logic [fwdW-1:0] fwdA, fwdB;

   // Execute to memory
   logic [15:0] memAlu, memStoreData;
   logic [regIdxW-1:0] memRd;
   logic memRegWrt, memMemRead, memMemWrt, memHalt, memIllegal;

   // Writeback
   logic wbValid;
   logic [regIdxW-1:0] wbRd;
   logic [15:0] wbData;

   fetchStage #(.imemDepth(imemDepth)) u_fetch (
      .clk, .rst, .loadEn, .loadAddr, .loadData, .stall, .redirect, .redirectPc,
      .stopFetch, .ifInstr, .ifPcNext
   );

   decodeStage u_decode (
      .clk, .rst, .ifInstr, .ifPcNext, .stall, .redirect, .wbValid, .wbRd, .wbData,
      .exRsData, .exRtData, .exImm, .exPcNext, .exRs, .exRt, .exRd, .exAluOp,
      .exUseImm, .exRegWrt, .exMemRead, .exMemWrt, .exBranch, .exJump, .exHalt,
      .exIllegal, .idRs, .idRt
   );

   hazardUnit u_hazard (
      .clk, .rst, .idRs, .idRt, .exRd, .exRegWrt, .exMemRead, .memRd, .memRegWrt,
      .stall, .fwdA, .fwdB
   );

   executeStage u_execute (
      .clk, .rst, .exRsData, .exRtData, .exImm, .exPcNext, .exRs, .exRt, .exRd,
      .exAluOp, .exUseImm, .exRegWrt, .exMemRead, .exMemWrt, .exBranch, .exJump,
      .exHalt, .exIllegal, .fwdA, .fwdB, .wbData, .redirect, .redirectPc, .memAlu,
      .memStoreData, .memRd, .memRegWrt, .memMemRead, .memMemWrt, .memHalt, .memIllegal
   );

   memoryStage #(.dmemDepth(dmemDepth)) u_memory (
      .clk, .rst, .memAlu, .memStoreData, .memRd, .memRegWrt, .memMemRead, .memMemWrt,
      .memHalt, .memIllegal, .wbValid, .wbRd, .wbData, .halted, .err, .stopFetch
   );

   // Every register write is a retire
   assign retire     = wbValid;
   assign retireReg  = wbRd;
   assign retireData = wbData;

endmodule

// ==== testbench/procTb.sv ====
`timescale 1ns/10ps

module procTb;

   localparam int imemDepth     = 256;
   localparam int dmemDepth     = 256;
   localparam int retireTimeout = 60;
   localparam int haltTimeout   = 60;
   localparam int quietCycles   = 30;

   logic        clk;
   logic        rst;
   logic        loadEn;
   logic [7:0]  loadAddr;
   logic [15:0] loadData;
   logic        retire;
   logic [2:0]  retireReg;
   logic [15:0] retireData;
   logic        halted;
   logic        err;

   // Per run: length, program, record count, records (test reg value), final flags
   logic [15:0] stim [0:255];
   int ptr;
   int errors;
   int checks;
   bit aborted;

   proc #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) u_dut (
      .clk(clk),
      .rst(rst),
      .loadEn(loadEn),
      .loadAddr(loadAddr),
      .loadData(loadData),
      .retire(retire),
      .retireReg(retireReg),
      .retireData(retireData),
      .halted(halted),
      .err(err)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic reportTest(input int num, input int errorsAtStart);
      if (errors == errorsAtStart) begin
         $display("Section %0d: ok", num);
      end else begin
         $display("Section %0d: %0d errors", num, errors - errorsAtStart);
      end
   endtask

   // Program goes in through the load port while the core sits in reset
   task automatic resetAndLoad;
      int len;
      len = int'(stim[ptr]);
      ptr++;
      @(negedge clk);
      rst = 1'b1;
      for (int i = 0; i < len; i++) begin
         @(negedge clk);
         loadEn   = 1'b1;
         loadAddr = 8'(i);
         loadData = stim[ptr];
         ptr++;
      end
      @(negedge clk);
      loadEn = 1'b0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
   endtask

   task automatic waitRetire(output bit seen);
      int n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < retireTimeout) begin
         @(negedge clk);
         if (retire) begin
            seen = 1'b1;
         end
         n++;
      end
   endtask

   task automatic waitHalted(output bit seen);
      int n;
      seen = 1'b0;
      n = 0;
      while (!seen && n < haltTimeout) begin
         @(negedge clk);
         if (halted) begin
            seen = 1'b1;
         end
         n++;
      end
   endtask

   task automatic runProgram;
      int count;
      int test;
      int lastTest;
      int startErrors;
      bit seen;
      resetAndLoad();
      count = int'(stim[ptr]);
      ptr++;
      lastTest = -1;
      startErrors = errors;
      for (int i = 0; i < count; i++) begin
         test = int'(stim[ptr]);
         if (test != lastTest) begin
            if (lastTest >= 0) begin
               reportTest(lastTest, startErrors);
            end
            lastTest = test;
            startErrors = errors;
         end
         waitRetire(seen);
         if (!seen) begin
            $display("No retire seen for record %0d of section %0d", i, test);
            errors++;
            aborted = 1'b1;
            return;
         end
         checkValue("retireReg", 16'(retireReg), stim[ptr + 1]);
         checkValue("retireData", retireData, stim[ptr + 2]);
         ptr += 3;
      end

      // Final flags carry their own section number
      test = int'(stim[ptr]);
      if (test != lastTest) begin
         if (lastTest >= 0) begin
            reportTest(lastTest, startErrors);
         end
         startErrors = errors;
      end
      waitHalted(seen);
      if (!seen) begin
         $display("Core never halted in section %0d", test);
         errors++;
         aborted = 1'b1;
         return;
      end
      // err rises in the same cycle as halted
      checkValue("err", {15'd0, err}, stim[ptr + 2]);

      // Nothing younger than the halt may retire
      for (int n = 0; n < quietCycles; n++) begin
         @(negedge clk);
         if (retire) begin
            $display("Unexpected retire of r%0d after the core halted", retireReg);
            errors++;
         end
      end

      // Both flags hold until the next reset
      checkValue("halted", {15'd0, halted}, stim[ptr + 1]);
      checkValue("err", {15'd0, err}, stim[ptr + 2]);
      ptr += 3;
      reportTest(test, startErrors);
   endtask

   initial begin
      rst      = 1'b1;
      loadEn   = 1'b0;
      loadAddr = 8'd0;
      loadData = 16'd0;
      ptr      = 0;
      errors   = 0;
      checks   = 0;
      aborted  = 1'b0;
      $readmemh("testbench/procStimulus.mem", stim);
      runProgram();
      if (!aborted) begin
         runProgram();
      end
      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// ==== testbench/procStimulus.mem ====
// Per run: program length, program words, record count,
// records as section reg value, then section halted err
001C
D800 4025 405D C14C C830 D294 DD38 46F0
4121 C128 C14C CB30
40AA 85E2 8DC2 C63C
6002 4021 4041 6101 4067 2002 4081 40A1 435F
0000 4029 4029
0011
0001 0000 0000
0001 0001 0005
0001 0002 FFFD
0001 0003 0002
0001 0004 FFFB
0001 0005 FFF9
0001 0006 FFFC
0001 0007 FFEC
0002 0001 0006
0002 0002 000C
0002 0003 0012
0002 0004 000C
0003 0005 000A
0003 0006 FFEC
0003 0007 FFF2
0004 0003 0007
0004 0002 0006
0005 0001 0000
// Second run ends in an unused opcode
0003
4023 F800 4041
0001
0006 0001 0003
0006 0001 0001

// ==== files.f ====
rtl/isaPkg.sv
rtl/pipePkg.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/hazardUnit.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/proc.sv
testbench/procTb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = procTb
FILELIST  = files.f
OBJDIR    = obj_dir

SOURCES = $(shell cat $(FILELIST))
SIM     = $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJDIR)
